/* filelist.f */
+incdir+hw
+incdir+verif
hw/ls_uop_pkg.sv
hw/ls_rs_pkg.sv
hw/ls_rs_if.sv
hw/ls_dispatch.sv
hw/ls_rs_entry.sv
hw/ls_issue_select.sv
hw/ls_rs_top.sv
verif/tb_ls_rs.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_ls_rs
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv verif/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_ls_rs_tasks.svh */
`ifndef TB_LS_RS_TASKS_SVH
`define TB_LS_RS_TASKS_SVH

// All tasks start and end 1 ns after a rising edge
task automatic step(input int n);
  repeat (n) @(posedge clk);
  #1;
endtask

function automatic uop_t random_uop(input inst_num_t num);
  uop_t u;
  u.inst_num   = num;
  u.rd         = phys_tag_t'(rand_bits(8));
  u.src1       = phys_tag_t'(rand_bits(8));
  u.src2       = phys_tag_t'(rand_bits(8));
  u.mem_to_reg = rand_bits(1) != 0;
  u.mem_read   = rand_bits(1) != 0;
  u.mem_write  = rand_bits(1) != 0;
  u.alu_op     = alu_op_t'(rand_bits(4));
  u.alu_src2   = rand_bits(1) != 0;
  u.funct3     = funct3_t'(rand_bits(3));
  u.imm        = rand_bits(32);
  return u;
endfunction

task automatic send_uop(input uop_t u, input logic r1, input logic r2);
  disp_valid    = 1'b1;
  disp_uop      = u;
  disp_src1_rdy = r1;
  disp_src2_rdy = r2;
  @(negedge clk);
  while (!disp_ready) begin
    @(negedge clk);
  end
  step(1);
  disp_valid = 1'b0;
endtask

task automatic broadcast(input int port, input phys_tag_t tag);
  wb_valid[port] = 1'b1;
  wb_tag[port]   = tag;
  step(1);
  wb_valid = '0;
endtask

task automatic wait_issues(input int n, input int limit, input logic toggle, input string what);
  int cycles;
  cycles = 0;
  while (issued_q.size() < n && cycles < limit) begin
    if (toggle) begin
      iss_ready = rand_bits(1) != 0;
    end
    step(1);
    cycles++;
  end
  if (toggle) begin
    iss_ready = 1'b1;
  end
  if (issued_q.size() < n) begin
    errors++;
    $display("Timed out after %0d cycles waiting for %0d issues in %s", limit, n, what);
  end
endtask

// Keep expected order by instruction number
task automatic push_sorted(input uop_t u);
  int pos;
  pos = 0;
  while (pos < expected_q.size() && expected_q[pos].inst_num < u.inst_num) begin
    pos++;
  end
  expected_q.insert(pos, u);
endtask

task automatic expect_issues(input string what);
  uop_t got;
  check(128'(issued_q.size()), 128'(expected_q.size()), {what, ": issue count"});
  foreach (expected_q[k]) begin
    if (issued_q.size() == 0) begin
      break;
    end
    got = issued_q.pop_front();
    check(128'(got), 128'(expected_q[k]), {what, ": issued micro-op"});
  end
  issued_q.delete();
  expected_q.delete();
endtask

// ==========================================================================
// Directed tests
// ==========================================================================
task automatic test_single_ready();
  uop_t u;
  u = random_uop(rand_bits(32));
  send_uop(u, 1'b1, 1'b1);
  check(128'(iss_valid), 128'(1'b0), "iss_valid right after accept");
  step(1);
  check(128'(iss_valid), 128'(1'b1), "iss_valid one cycle after accept");
  check(128'(iss_uop), 128'(u), "iss fields one cycle after accept");
  wait_issues(1, 4, 1'b0, "single ready");
  expected_q.push_back(u);
  expect_issues("single ready");
endtask

task automatic test_wakeup();
  uop_t u;
  u      = random_uop(rand_bits(32));
  u.src1 = 8'h21;
  u.src2 = 8'h22;
  send_uop(u, 1'b0, 1'b0);
  step(3);
  check(128'(issued_q.size()), 128'(0), "issue before any wakeup");
  broadcast(1, 8'h21);
  // Matching tag without valid
  wb_tag[5] = 8'h22;
  step(3);
  check(128'(issued_q.size()), 128'(0), "issue with one operand pending");
  broadcast(6, 8'h22);
  step(1);
  check(128'(iss_valid), 128'(1'b1), "iss_valid one cycle after last wakeup");
  wait_issues(1, 4, 1'b0, "wakeup");
  expected_q.push_back(u);
  expect_issues("wakeup");
  // Both results land in the dispatch cycle
  u            = random_uop(rand_bits(32));
  u.src1       = 8'h31;
  u.src2       = 8'h32;
  wb_valid[3]  = 1'b1;
  wb_tag[3]    = 8'h31;
  wb_valid[4]  = 1'b1;
  wb_tag[4]    = 8'h32;
  send_uop(u, 1'b0, 1'b0);
  wb_valid = '0;
  step(1);
  check(128'(iss_valid), 128'(1'b1), "iss_valid after same-cycle wakeup");
  wait_issues(1, 4, 1'b0, "same-cycle wakeup");
  expected_q.push_back(u);
  expect_issues("same-cycle wakeup");
endtask

task automatic test_oldest_first();
  uop_t u;
  for (int k = 0; k < 5; k++) begin
    // Low bits keep numbers distinct, high bits scramble the order
    u      = random_uop(inst_num_t'((rand_bits(13) << 3) | k));
    u.src1 = 8'h40;
    send_uop(u, 1'b0, 1'b1);
    push_sorted(u);
  end
  broadcast(0, 8'h40);
  wait_issues(5, 20, 1'b0, "oldest first");
  expect_issues("oldest first");
endtask

task automatic test_full_station();
  uop_t      uops [8];
  inst_num_t base;
  int        idx;
  base = inst_num_t'(rand_bits(20));
  for (int k = 0; k < 8; k++) begin
    uops[k]      = random_uop(base + inst_num_t'(k));
    uops[k].src1 = phys_tag_t'(8'h50 + k);
    send_uop(uops[k], 1'b0, 1'b1);
  end
  check(128'(disp_ready), 128'(1'b0), "disp_ready with station full");
  broadcast(2, 8'h55);
  wait_issues(1, 6, 1'b0, "drain one");
  check(128'(disp_ready), 128'(1'b1), "disp_ready after one drained");
  expected_q.push_back(uops[5]);
  expect_issues("drain one");
  // Remaining seven wake together on separate buses
  for (int p = 0; p < `LS_RS_WB_PORTS; p++) begin
    idx         = (p < 5) ? p : p + 1;
    wb_valid[p] = 1'b1;
    wb_tag[p]   = uops[idx].src1;
    expected_q.push_back(uops[idx]);
  end
  step(1);
  wb_valid = '0;
  wait_issues(7, 20, 1'b0, "drain all");
  expect_issues("drain all");
endtask

task automatic test_back_pressure();
  uop_t      u;
  inst_num_t base;
  base      = inst_num_t'(rand_bits(20));
  iss_ready = 1'b0;
  for (int k = 0; k < 3; k++) begin
    u = random_uop(base + inst_num_t'(k));
    send_uop(u, 1'b1, 1'b1);
    expected_q.push_back(u);
  end
  step(6);
  check(128'(iss_valid), 128'(1'b1), "iss_valid held under back-pressure");
  check(128'(iss_uop), 128'(expected_q[0]), "held micro-op under back-pressure");
  wait_issues(3, 40, 1'b1, "back-pressure");
  step(4);
  expect_issues("back-pressure");
endtask

task automatic test_flush();
  uop_t u;
  iss_ready = 1'b0;
  send_uop(random_uop(rand_bits(32)), 1'b1, 1'b1);
  // Occupy all slots but one behind the stalled output
  for (int k = 0; k < `LS_RS_ENTRIES - 1; k++) begin
    u      = random_uop(rand_bits(32));
    u.src1 = 8'h60;
    send_uop(u, 1'b0, 1'b1);
  end
  step(2);
  // Dispatch in the flush cycle is dropped
  disp_uop      = random_uop(rand_bits(32));
  disp_src1_rdy = 1'b1;
  disp_src2_rdy = 1'b1;
  disp_valid    = 1'b1;
  flush         = 1'b1;
  step(1);
  flush      = 1'b0;
  disp_valid = 1'b0;
  check(128'(iss_valid), 128'(1'b0), "iss_valid after flush");
  check(128'(disp_ready), 128'(1'b1), "disp_ready after flush");
  iss_ready = 1'b1;
  broadcast(0, 8'h60);
  step(5);
  check(128'(issued_q.size()), 128'(0), "issue after flush");
  u = random_uop(rand_bits(32));
  send_uop(u, 1'b1, 1'b1);
  wait_issues(1, 6, 1'b0, "after flush");
  expected_q.push_back(u);
  expect_issues("after flush");
endtask

`endif

/* verif/tb_ls_rs.sv */
`default_nettype none

`include "ls_rs_defs.svh"

module tb_ls_rs
  import ls_uop_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] LFSR_SEED    = 32'd88;
  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 16;
  // Worst-case cycles of each test in run order
  localparam int          TEST_CYCLES  = 20 + 40 + 40 + 60 + 70 + 40;
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + 2 * TEST_CYCLES) * CLK_PERIOD;

  typedef struct packed {
    inst_num_t inst_num;
    phys_tag_t rd;
    phys_tag_t src1;
    phys_tag_t src2;
    logic      mem_to_reg;
    logic      mem_read;
    logic      mem_write;
    alu_op_t   alu_op;
    logic      alu_src2;
    funct3_t   funct3;
    imm_t      imm;
  } uop_t;

  logic                       clk;
  logic                       rst;
  logic                       flush;
  logic                       disp_valid;
  logic                       disp_ready;
  uop_t                       disp_uop;
  logic                       disp_src1_rdy;
  logic                       disp_src2_rdy;
  logic [`LS_RS_WB_PORTS-1:0] wb_valid;
  phys_tag_t                  wb_tag [`LS_RS_WB_PORTS];
  logic                       iss_ready;
  logic                       iss_valid;
  inst_num_t                  iss_inst_num;
  phys_tag_t                  iss_rd;
  phys_tag_t                  iss_src1;
  phys_tag_t                  iss_src2;
  logic                       iss_mem_to_reg;
  logic                       iss_mem_read;
  logic                       iss_mem_write;
  alu_op_t                    iss_alu_op;
  logic                       iss_alu_src2;
  funct3_t                    iss_funct3;
  imm_t                       iss_imm;
  uop_t                       iss_uop;

  logic [31:0] lfsr_state;
  int          errors = 0;
  int          checks = 0;
  uop_t        issued_q [$];
  uop_t        expected_q [$];
  uop_t        held_uop;
  logic        stalled;

  ls_rs_top ls_rs_top_i (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .disp_valid      (disp_valid),
    .disp_ready      (disp_ready),
    .disp_inst_num   (disp_uop.inst_num),
    .disp_rd         (disp_uop.rd),
    .disp_mem_to_reg (disp_uop.mem_to_reg),
    .disp_mem_read   (disp_uop.mem_read),
    .disp_mem_write  (disp_uop.mem_write),
    .disp_alu_op     (disp_uop.alu_op),
    .disp_alu_src2   (disp_uop.alu_src2),
    .disp_funct3     (disp_uop.funct3),
    .disp_imm        (disp_uop.imm),
    .disp_src1       (disp_uop.src1),
    .disp_src2       (disp_uop.src2),
    .disp_src1_rdy   (disp_src1_rdy),
    .disp_src2_rdy   (disp_src2_rdy),
    .wb_valid        (wb_valid),
    .wb_tag          (wb_tag),
    .iss_ready       (iss_ready),
    .iss_valid       (iss_valid),
    .iss_inst_num    (iss_inst_num),
    .iss_rd          (iss_rd),
    .iss_src1        (iss_src1),
    .iss_src2        (iss_src2),
    .iss_mem_to_reg  (iss_mem_to_reg),
    .iss_mem_read    (iss_mem_read),
    .iss_mem_write   (iss_mem_write),
    .iss_alu_op      (iss_alu_op),
    .iss_alu_src2    (iss_alu_src2),
    .iss_funct3      (iss_funct3),
    .iss_imm         (iss_imm)
  );

  assign iss_uop = {iss_inst_num, iss_rd, iss_src1, iss_src2, iss_mem_to_reg, iss_mem_read,
                    iss_mem_write, iss_alu_op, iss_alu_src2, iss_funct3, iss_imm};

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Right-shifting Galois LFSR with taps x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
    end
  endtask

  // ==========================================================================
  // Issue monitor sampled mid-cycle
  // ==========================================================================
  always @(negedge clk) begin
    if (rst) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check(128'(iss_valid), 128'(1'b1), "iss_valid dropped while stalled");
        check(128'(iss_uop), 128'(held_uop), "iss fields changed while stalled");
      end
      if (iss_valid && iss_ready) begin
        issued_q.push_back(iss_uop);
      end
      stalled  = iss_valid && !iss_ready && !flush;
      held_uop = iss_uop;
    end
  end

  `include "tb_ls_rs_tasks.svh"

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    lfsr_state    = LFSR_SEED;
    rst           = 1'b1;
    flush         = 1'b0;
    disp_valid    = 1'b0;
    disp_uop      = '0;
    disp_src1_rdy = 1'b0;
    disp_src2_rdy = 1'b0;
    wb_valid      = '0;
    iss_ready     = 1'b1;
    foreach (wb_tag[p]) begin
      wb_tag[p] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    test_single_ready();
    test_wakeup();
    test_oldest_first();
    test_full_station();
    test_back_pressure();
    test_flush();
    step(4);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/ls_rs_top.sv */
`default_nettype none

`include "ls_rs_defs.svh"

module ls_rs_top
  import ls_uop_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush,

  input  logic                        disp_valid,
  output logic                        disp_ready,
  input  inst_num_t                   disp_inst_num,
  input  phys_tag_t                   disp_rd,
  input  logic                        disp_mem_to_reg,
  input  logic                        disp_mem_read,
  input  logic                        disp_mem_write,
  input  alu_op_t                     disp_alu_op,
  input  logic                        disp_alu_src2,
  input  funct3_t                     disp_funct3,
  input  imm_t                        disp_imm,
  input  phys_tag_t                   disp_src1,
  input  phys_tag_t                   disp_src2,
  input  logic                        disp_src1_rdy,
  input  logic                        disp_src2_rdy,

  input  logic [`LS_RS_WB_PORTS-1:0]  wb_valid,
  input  phys_tag_t                   wb_tag [`LS_RS_WB_PORTS],

  input  logic                        iss_ready,
  output logic                        iss_valid,
  output inst_num_t                   iss_inst_num,
  output phys_tag_t                   iss_rd,
  output phys_tag_t                   iss_src1,
  output phys_tag_t                   iss_src2,
  output logic                        iss_mem_to_reg,
  output logic                        iss_mem_read,
  output logic                        iss_mem_write,
  output alu_op_t                     iss_alu_op,
  output logic                        iss_alu_src2,
  output funct3_t                     iss_funct3,
  output imm_t                        iss_imm
);

  ls_rs_alloc_if alloc_if ();
  ls_rs_issue_if issue_if ();

  ls_dispatch dispatch_i (
    .disp_valid      (disp_valid),
    .disp_inst_num   (disp_inst_num),
    .disp_rd         (disp_rd),
    .disp_mem_to_reg (disp_mem_to_reg),
    .disp_mem_read   (disp_mem_read),
    .disp_mem_write  (disp_mem_write),
    .disp_alu_op     (disp_alu_op),
    .disp_alu_src2   (disp_alu_src2),
    .disp_funct3     (disp_funct3),
    .disp_imm        (disp_imm),
    .disp_src1       (disp_src1),
    .disp_src2       (disp_src2),
    .disp_src1_rdy   (disp_src1_rdy),
    .disp_src2_rdy   (disp_src2_rdy),
    .wb_valid        (wb_valid),
    .wb_tag          (wb_tag),
    .disp_ready      (disp_ready),
    .alloc           (alloc_if.dispatch)
  );

  // ==========================================================================
  // Station slots
  // ==========================================================================
  for (genvar i = 0; i < `LS_RS_ENTRIES; i++) begin : g_entry
    ls_rs_entry entry_i (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .wb_valid   (wb_valid),
      .wb_tag     (wb_tag),
      .wr         (alloc_if.wr_en[i]),
      .alloc      (alloc_if.entry),
      .grant      (issue_if.grant[i]),
      .free       (alloc_if.free[i]),
      .req        (issue_if.req[i]),
      .inst_num   (issue_if.inst_num[i]),
      .rd         (issue_if.rd[i]),
      .mem_to_reg (issue_if.mem_to_reg[i]),
      .mem_read   (issue_if.mem_read[i]),
      .mem_write  (issue_if.mem_write[i]),
      .alu_op     (issue_if.alu_op[i]),
      .alu_src2   (issue_if.alu_src2[i]),
      .funct3     (issue_if.funct3[i]),
      .imm        (issue_if.imm[i]),
      .src1       (issue_if.src1[i]),
      .src2       (issue_if.src2[i])
    );
  end

  ls_issue_select select_i (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .issue          (issue_if.select),
    .iss_ready      (iss_ready),
    .iss_valid      (iss_valid),
    .iss_inst_num   (iss_inst_num),
    .iss_rd         (iss_rd),
    .iss_src1       (iss_src1),
    .iss_src2       (iss_src2),
    .iss_mem_to_reg (iss_mem_to_reg),
    .iss_mem_read   (iss_mem_read),
    .iss_mem_write  (iss_mem_write),
    .iss_alu_op     (iss_alu_op),
    .iss_alu_src2   (iss_alu_src2),
    .iss_funct3     (iss_funct3),
    .iss_imm        (iss_imm)
  );

endmodule

`default_nettype wire

/* hw/ls_issue_select.sv */
`default_nettype none

`include "ls_rs_defs.svh"

module ls_issue_select
  import ls_uop_pkg::*;
  import ls_rs_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            flush,

  ls_rs_issue_if.select   issue,

  input  logic            iss_ready,
  output logic            iss_valid,
  output inst_num_t       iss_inst_num,
  output phys_tag_t       iss_rd,
  output phys_tag_t       iss_src1,
  output phys_tag_t       iss_src2,
  output logic            iss_mem_to_reg,
  output logic            iss_mem_read,
  output logic            iss_mem_write,
  output alu_op_t         iss_alu_op,
  output logic            iss_alu_src2,
  output funct3_t         iss_funct3,
  output imm_t            iss_imm
);

  logic       found;
  entry_idx_t sel;
  logic       load;

  // ==========================================================================
  // Oldest ready requester
  // ==========================================================================

  // Strict compare keeps the lower index on a tie
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < `LS_RS_ENTRIES; i++) begin
      if (issue.req[i] && (!found || issue.inst_num[i] < issue.inst_num[sel])) begin
        found = 1'b1;
        sel   = entry_idx_t'(i);
      end
    end
  end

  // Output slot is empty or drains this cycle
  assign load = found && !flush && (!iss_valid || iss_ready);

  assign issue.grant = load ? (entry_vec_t'(1) << sel) : '0;

  // ==========================================================================
  // Issue register
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      iss_valid <= 1'b0;
    end else if (load) begin
      iss_valid <= 1'b1;
    end else if (iss_ready) begin
      iss_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      iss_inst_num   <= issue.inst_num[sel];
      iss_rd         <= issue.rd[sel];
      iss_src1       <= issue.src1[sel];
      iss_src2       <= issue.src2[sel];
      iss_mem_to_reg <= issue.mem_to_reg[sel];
      iss_mem_read   <= issue.mem_read[sel];
      iss_mem_write  <= issue.mem_write[sel];
      iss_alu_op     <= issue.alu_op[sel];
      iss_alu_src2   <= issue.alu_src2[sel];
      iss_funct3     <= issue.funct3[sel];
      iss_imm        <= issue.imm[sel];
    end
  end

endmodule

`default_nettype wire

/* hw/ls_rs_entry.sv */
`default_nettype none

`include "ls_rs_defs.svh"

module ls_rs_entry
  import ls_uop_pkg::*;
  import ls_rs_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush,

  input  logic [`LS_RS_WB_PORTS-1:0]  wb_valid,
  input  phys_tag_t                   wb_tag [`LS_RS_WB_PORTS],

  input  logic                        wr,
  ls_rs_alloc_if.entry                alloc,
  input  logic                        grant,

  output logic                        free,
  output logic                        req,
  output inst_num_t                   inst_num,
  output phys_tag_t                   rd,
  output logic                        mem_to_reg,
  output logic                        mem_read,
  output logic                        mem_write,
  output alu_op_t                     alu_op,
  output logic                        alu_src2,
  output funct3_t                     funct3,
  output imm_t                        imm,
  output phys_tag_t                   src1,
  output phys_tag_t                   src2
);

  entry_state_e state;
  logic         rdy1;
  logic         rdy2;
  logic         rdy1_now;
  logic         rdy2_now;

  // Snoop every bus for pending operands
  assign rdy1_now = rdy1 || wb_match(src1, wb_valid, wb_tag);
  assign rdy2_now = rdy2 || wb_match(src2, wb_valid, wb_tag);

  assign free = (state == EMPTY);
  assign req  = (state == READY);

  // ==========================================================================
  // Slot FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state <= EMPTY;
      rdy1  <= 1'b0;
      rdy2  <= 1'b0;
    end else if (grant) begin
      state <= EMPTY;
    end else begin
      case (state)
        EMPTY: begin
          if (wr) begin
            rdy1  <= alloc.src1_rdy;
            rdy2  <= alloc.src2_rdy;
            state <= (alloc.src1_rdy && alloc.src2_rdy) ? READY : WAITING;
          end
        end
        WAITING: begin
          rdy1 <= rdy1_now;
          rdy2 <= rdy2_now;
          if (rdy1_now && rdy2_now) begin
            state <= READY;
          end
        end
        default: ;
      endcase
    end
  end

  // Payload taken on write
  always_ff @(posedge clk) begin
    if (wr) begin
      inst_num   <= alloc.inst_num;
      rd         <= alloc.rd;
      mem_to_reg <= alloc.mem_to_reg;
      mem_read   <= alloc.mem_read;
      mem_write  <= alloc.mem_write;
      alu_op     <= alloc.alu_op;
      alu_src2   <= alloc.alu_src2;
      funct3     <= alloc.funct3;
      imm        <= alloc.imm;
      src1       <= alloc.src1;
      src2       <= alloc.src2;
    end
  end

endmodule

`default_nettype wire

/* hw/ls_dispatch.sv */
`default_nettype none

`include "ls_rs_defs.svh"

module ls_dispatch
  import ls_uop_pkg::*;
  import ls_rs_pkg::*;
(
  input  logic                        disp_valid,
  input  inst_num_t                   disp_inst_num,
  input  phys_tag_t                   disp_rd,
  input  logic                        disp_mem_to_reg,
  input  logic                        disp_mem_read,
  input  logic                        disp_mem_write,
  input  alu_op_t                     disp_alu_op,
  input  logic                        disp_alu_src2,
  input  funct3_t                     disp_funct3,
  input  imm_t                        disp_imm,
  input  phys_tag_t                   disp_src1,
  input  phys_tag_t                   disp_src2,
  input  logic                        disp_src1_rdy,
  input  logic                        disp_src2_rdy,

  input  logic [`LS_RS_WB_PORTS-1:0]  wb_valid,
  input  phys_tag_t                   wb_tag [`LS_RS_WB_PORTS],

  output logic                        disp_ready,
  ls_rs_alloc_if.dispatch             alloc
);

  entry_vec_t lowest_free;
  logic       accept;

  // ==========================================================================
  // Slot choice
  // ==========================================================================

  // Isolate lowest set bit of the free vector
  assign lowest_free = alloc.free & (~alloc.free + entry_vec_t'(1));

  assign disp_ready = |alloc.free;
  assign accept     = disp_valid && disp_ready;

  assign alloc.wr_en = accept ? lowest_free : '0;

  // ==========================================================================
  // Micro-op forwarding
  // ==========================================================================
  assign alloc.inst_num   = disp_inst_num;
  assign alloc.rd         = disp_rd;
  assign alloc.mem_to_reg = disp_mem_to_reg;
  assign alloc.mem_read   = disp_mem_read;
  assign alloc.mem_write  = disp_mem_write;
  assign alloc.alu_op     = disp_alu_op;
  assign alloc.alu_src2   = disp_alu_src2;
  assign alloc.funct3     = disp_funct3;
  assign alloc.imm        = disp_imm;
  assign alloc.src1       = disp_src1;
  assign alloc.src2       = disp_src2;

  // Result landing in the dispatch cycle counts as ready
  assign alloc.src1_rdy = disp_src1_rdy || wb_match(disp_src1, wb_valid, wb_tag);
  assign alloc.src2_rdy = disp_src2_rdy || wb_match(disp_src2, wb_valid, wb_tag);

endmodule

`default_nettype wire

/* hw/ls_rs_if.sv */
`default_nettype none

`include "ls_rs_defs.svh"

// ==========================================================================
// Dispatch to slots
// ==========================================================================
interface ls_rs_alloc_if
  import ls_uop_pkg::*;
  import ls_rs_pkg::*;
();

  entry_vec_t wr_en;
  entry_vec_t free;

  inst_num_t  inst_num;
  phys_tag_t  rd;
  logic       mem_to_reg;
  logic       mem_read;
  logic       mem_write;
  alu_op_t    alu_op;
  logic       alu_src2;
  funct3_t    funct3;
  imm_t       imm;
  phys_tag_t  src1;
  phys_tag_t  src2;
  logic       src1_rdy;
  logic       src2_rdy;

  modport dispatch (
    output wr_en, inst_num, rd, mem_to_reg, mem_read, mem_write, alu_op,
           alu_src2, funct3, imm, src1, src2, src1_rdy, src2_rdy,
    input  free
  );

  // Write strobe and free flag go per slot through the top
  modport entry (
    input inst_num, rd, mem_to_reg, mem_read, mem_write, alu_op,
          alu_src2, funct3, imm, src1, src2, src1_rdy, src2_rdy
  );

endinterface

// ==========================================================================
// Slots to issue selector
// ==========================================================================
interface ls_rs_issue_if
  import ls_uop_pkg::*;
  import ls_rs_pkg::*;
();

  entry_vec_t req;
  entry_vec_t grant;

  inst_num_t  inst_num   [`LS_RS_ENTRIES];
  phys_tag_t  rd         [`LS_RS_ENTRIES];
  logic       mem_to_reg [`LS_RS_ENTRIES];
  logic       mem_read   [`LS_RS_ENTRIES];
  logic       mem_write  [`LS_RS_ENTRIES];
  alu_op_t    alu_op     [`LS_RS_ENTRIES];
  logic       alu_src2   [`LS_RS_ENTRIES];
  funct3_t    funct3     [`LS_RS_ENTRIES];
  imm_t       imm        [`LS_RS_ENTRIES];
  phys_tag_t  src1       [`LS_RS_ENTRIES];
  phys_tag_t  src2       [`LS_RS_ENTRIES];

  modport entry (
    output req, inst_num, rd, mem_to_reg, mem_read, mem_write, alu_op,
           alu_src2, funct3, imm, src1, src2,
    input  grant
  );

  modport select (
    input  req, inst_num, rd, mem_to_reg, mem_read, mem_write, alu_op,
           alu_src2, funct3, imm, src1, src2,
    output grant
  );

endinterface

`default_nettype wire

/* hw/ls_rs_pkg.sv */
`default_nettype none

`include "ls_rs_defs.svh"

package ls_rs_pkg;

  typedef logic [`LS_RS_IDX_W-1:0]   entry_idx_t;
  typedef logic [`LS_RS_ENTRIES-1:0] entry_vec_t;

  // Slot life cycle
  typedef enum logic [1:0] {
    EMPTY,
    WAITING,
    READY
  } entry_state_e;

endpackage

`default_nettype wire

/* hw/ls_uop_pkg.sv */
`default_nettype none

`include "ls_rs_defs.svh"

package ls_uop_pkg;

  typedef logic [`LS_RS_TAG_W-1:0] phys_tag_t;
  typedef logic [31:0]             inst_num_t;
  typedef logic [31:0]             imm_t;
  typedef logic [3:0]              alu_op_t;
  typedef logic [2:0]              funct3_t;

  // True when any valid broadcast carries this tag
  function automatic logic wb_match(
    input phys_tag_t                   tag,
    input logic [`LS_RS_WB_PORTS-1:0]  wb_valid,
    input phys_tag_t                   wb_tag [`LS_RS_WB_PORTS]
  );
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < `LS_RS_WB_PORTS; p++) begin
      hit |= wb_valid[p] && (wb_tag[p] == tag);
    end
    return hit;
  endfunction

endpackage

`default_nettype wire

/* hw/ls_rs_defs.svh */
`ifndef LS_RS_DEFS_SVH
`define LS_RS_DEFS_SVH

// ==========================================================================
// Load/store reservation station sizing
// ==========================================================================

// Station slots
`define LS_RS_ENTRIES 8

// Bits to index one slot
`define LS_RS_IDX_W 3

// Physical register tag width
`define LS_RS_TAG_W 8

// Result broadcast buses for ALU, MUL, DIV, load, branch, P unit and CSR
`define LS_RS_WB_PORTS 7

`endif
